/* src/lvdcPkg.sv */
package lvdcPkg;

    ///////////////////////////////
    // Word geometry
    ///////////////////////////////
    localparam int SYL_BITS  = 13;
    localparam int OP_BITS   = 4;
    localparam int ADDR_BITS = SYL_BITS - OP_BITS;
    localparam int WORD_BITS = 2 * SYL_BITS;
    localparam int MEM_WORDS = 1 << ADDR_BITS;

    ///////////////////////////////
    // Instruction set
    ///////////////////////////////
    localparam logic [OP_BITS-1:0] OP_HLT = 4'd0;
    localparam logic [OP_BITS-1:0] OP_CLA = 4'd1;
    localparam logic [OP_BITS-1:0] OP_ADD = 4'd2;
    localparam logic [OP_BITS-1:0] OP_SUB = 4'd3;
    localparam logic [OP_BITS-1:0] OP_AND = 4'd4;
    localparam logic [OP_BITS-1:0] OP_STO = 4'd5;
    localparam logic [OP_BITS-1:0] OP_TRA = 4'd6;

    // Sequencer FSM
    localparam logic [2:0] SEQ_IDLE   = 3'd0;
    localparam logic [2:0] SEQ_LOAD   = 3'd1;
    localparam logic [2:0] SEQ_DECODE = 3'd2;
    localparam logic [2:0] SEQ_WAIT   = 3'd3;
    localparam logic [2:0] SEQ_DROP   = 3'd4;

    // Arithmetic unit FSM
    localparam logic [2:0] ALU_IDLE  = 3'd0;
    localparam logic [2:0] ALU_FETCH = 3'd1;
    localparam logic [2:0] ALU_SYNC  = 3'd2;
    localparam logic [2:0] ALU_SHIFT = 3'd3;
    localparam logic [2:0] ALU_STORE = 3'd4;
    localparam logic [2:0] ALU_DONE  = 3'd5;

    typedef struct packed {
        logic [OP_BITS-1:0]   opcode;
        logic [ADDR_BITS-1:0] address;
    } lvdcSyllable_t;

    // Syllable 0 sits in the low half and runs first
    typedef union packed {
        logic [WORD_BITS-1:0]    data;
        lvdcSyllable_t [1:0]     syl;
    } lvdcWord_u;

endpackage

/* src/timingGenerator.sv */
`timescale 1ns/1ps
`default_nettype none

module timingGenerator
    import lvdcPkg::*;
(
    input  logic       clk,
    input  logic       rst,
    output logic [4:0] bitIndex,
    output logic       wordStart
);

    // One bit time per clock, 26 bit times per word
    always_ff @(posedge clk) begin
        if (rst) begin
            bitIndex <= '0;
        end else if (bitIndex == 5'(WORD_BITS - 1)) begin
            bitIndex <= '0;
        end else begin
            bitIndex <= bitIndex + 5'd1;
        end
    end

    // Bit time 0 carries the least significant bit of every word
    assign wordStart = (bitIndex == 5'd0);

endmodule

`default_nettype wire

/* src/wordMemory.sv */
`timescale 1ns/1ps
`default_nettype none

module wordMemory
    import lvdcPkg::*;
(
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 memReq,
    input  logic [ADDR_BITS-1:0] memAddr,
    input  logic                 memWe,
    input  logic [WORD_BITS-1:0] memWdata,
    output logic                 memAck,
    output logic [WORD_BITS-1:0] memRdata
);

    lvdcWord_u store [MEM_WORDS];

    // Ack trails req by one cycle on both the rising and the falling side
    always_ff @(posedge clk) begin
        if (rst) begin
            memAck <= 1'b0;
        end else begin
            memAck <= memReq;
        end
    end

    // The access happens on the edge that raises ack
    always_ff @(posedge clk) begin
        if (memReq && !memAck) begin
            if (memWe) begin
                store[memAddr].data <= memWdata;
            end
            memRdata <= store[memAddr].data;
        end
    end

endmodule

`default_nettype wire

/* src/memoryArbiter.sv */
`timescale 1ns/1ps
`default_nettype none

module memoryArbiter
    import lvdcPkg::*;
(
    input  logic                 clk,
    input  logic                 rst,

    input  logic                 extReq,
    input  logic [ADDR_BITS-1:0] extAddr,
    input  logic                 extWe,
    input  logic [WORD_BITS-1:0] extWdata,
    output logic                 extAck,
    output logic [WORD_BITS-1:0] extRdata,

    input  logic                 opndReq,
    input  logic [ADDR_BITS-1:0] opndAddr,
    input  logic                 opndWe,
    input  logic [WORD_BITS-1:0] opndWdata,
    output logic                 opndAck,
    output logic [WORD_BITS-1:0] opndRdata,

    input  logic                 ifetchReq,
    input  logic [ADDR_BITS-1:0] ifetchAddr,
    output logic                 ifetchAck,
    output logic [WORD_BITS-1:0] ifetchRdata,

    output logic                 memReq,
    output logic [ADDR_BITS-1:0] memAddr,
    output logic                 memWe,
    output logic [WORD_BITS-1:0] memWdata,
    input  logic                 memAck,
    input  logic [WORD_BITS-1:0] memRdata
);

    logic extGrant;
    logic opndGrant;
    logic ifetchGrant;
    logic anyGrant;

    assign anyGrant = extGrant | opndGrant | ifetchGrant;

    // A new winner is picked only once the previous handshake has fully closed
    always_ff @(posedge clk) begin
        if (rst) begin
            extGrant    <= 1'b0;
            opndGrant   <= 1'b0;
            ifetchGrant <= 1'b0;
        end else if (!anyGrant) begin
            extGrant    <= extReq;
            opndGrant   <= !extReq && opndReq;
            ifetchGrant <= !extReq && !opndReq && ifetchReq;
        end else if (!memReq && !memAck) begin
            extGrant    <= 1'b0;
            opndGrant   <= 1'b0;
            ifetchGrant <= 1'b0;
        end
    end

    assign memReq = (extGrant & extReq) | (opndGrant & opndReq) | (ifetchGrant & ifetchReq);

    always_comb begin
        if (extGrant) begin
            memAddr  = extAddr;
            memWe    = extWe;
            memWdata = extWdata;
        end else if (opndGrant) begin
            memAddr  = opndAddr;
            memWe    = opndWe;
            memWdata = opndWdata;
        end else begin
            memAddr  = ifetchAddr;
            memWe    = 1'b0;
            memWdata = '0;
        end
    end

    assign extAck      = extGrant & memAck;
    assign opndAck     = opndGrant & memAck;
    assign ifetchAck   = ifetchGrant & memAck;
    assign extRdata    = extGrant ? memRdata : '0;
    assign opndRdata   = opndGrant ? memRdata : '0;
    assign ifetchRdata = ifetchGrant ? memRdata : '0;

endmodule

`default_nettype wire

/* src/instructionSequencer.sv */
`timescale 1ns/1ps
`default_nettype none

module instructionSequencer
    import lvdcPkg::*;
(
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 start,
    output logic                 halted,
    output logic                 ifetchReq,
    output logic [ADDR_BITS-1:0] ifetchAddr,
    input  logic                 ifetchAck,
    input  logic [WORD_BITS-1:0] ifetchRdata,
    output logic                 execReq,
    output logic [OP_BITS-1:0]   execOpcode,
    output logic [ADDR_BITS-1:0] execAddr,
    input  logic                 execAck
);

    logic [2:0]           state;
    logic [ADDR_BITS-1:0] pc;
    lvdcWord_u            curWord;
    lvdcWord_u            nextWord;
    logic                 nextValid;
    logic                 sylSel;
    logic                 discard;
    lvdcSyllable_t        curSyl;
    logic                 isHalt;
    logic                 wantFetch;
    logic                 inFlight;
    logic                 launch;

    assign curSyl = curWord.syl[sylSel];

    // Unassigned opcodes stop the machine just as HLT does
    assign isHalt = (curSyl.opcode == OP_HLT) || (curSyl.opcode > OP_TRA);

    // Prefetch runs alongside syllable 1
    assign wantFetch = (state == SEQ_LOAD) || (state != SEQ_IDLE && sylSel);
    assign inFlight  = ifetchReq && !ifetchAck;
    assign launch    = wantFetch && !ifetchReq && !ifetchAck && !nextValid;

    always_ff @(posedge clk) begin
        if (rst) begin
            state      <= SEQ_IDLE;
            pc         <= '0;
            sylSel     <= 1'b0;
            nextValid  <= 1'b0;
            discard    <= 1'b0;
            ifetchReq  <= 1'b0;
            ifetchAddr <= '0;
            execReq    <= 1'b0;
            execOpcode <= '0;
            execAddr   <= '0;
            halted     <= 1'b0;
        end else begin
            ///////////////////////////////
            // Fetch engine
            ///////////////////////////////
            if (ifetchReq && ifetchAck) begin
                ifetchReq     <= 1'b0;
                nextWord.data <= ifetchRdata;
                nextValid     <= !discard;
                discard       <= 1'b0;
            end else if (launch) begin
                ifetchReq  <= 1'b1;
                ifetchAddr <= pc;
                pc         <= pc + 1'b1;
            end

            ///////////////////////////////
            // Syllable control
            ///////////////////////////////
            case (state)
                SEQ_IDLE: begin
                    if (start) begin
                        pc        <= '0;
                        sylSel    <= 1'b0;
                        halted    <= 1'b0;
                        nextValid <= 1'b0;
                        discard   <= inFlight;
                        state     <= SEQ_LOAD;
                    end
                end
                SEQ_LOAD: begin
                    if (nextValid) begin
                        curWord   <= nextWord;
                        nextValid <= 1'b0;
                        sylSel    <= 1'b0;
                        state     <= SEQ_DECODE;
                    end
                end
                SEQ_DECODE: begin
                    if (isHalt) begin
                        halted <= 1'b1;
                        state  <= SEQ_IDLE;
                    end else if (curSyl.opcode == OP_TRA) begin
                        // Whatever the prefetch brings back is stale now
                        pc        <= curSyl.address;
                        nextValid <= 1'b0;
                        discard   <= inFlight || launch;
                        state     <= SEQ_LOAD;
                    end else begin
                        execReq    <= 1'b1;
                        execOpcode <= curSyl.opcode;
                        execAddr   <= curSyl.address;
                        state      <= SEQ_WAIT;
                    end
                end
                SEQ_WAIT: begin
                    if (execAck) begin
                        execReq <= 1'b0;
                        state   <= SEQ_DROP;
                    end
                end
                SEQ_DROP: begin
                    if (!execAck) begin
                        if (sylSel) begin
                            state <= SEQ_LOAD;
                        end else begin
                            sylSel <= 1'b1;
                            state  <= SEQ_DECODE;
                        end
                    end
                end
                default: begin
                    state <= SEQ_IDLE;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

/* src/serialArithmetic.sv */
`timescale 1ns/1ps
`default_nettype none

module serialArithmetic
    import lvdcPkg::*;
(
    input  logic                 clk,
    input  logic                 rst,
    input  logic [4:0]           bitIndex,
    input  logic                 wordStart,
    input  logic                 execReq,
    input  logic [OP_BITS-1:0]   execOpcode,
    input  logic [ADDR_BITS-1:0] execAddr,
    output logic                 execAck,
    output logic                 opndReq,
    output logic [ADDR_BITS-1:0] opndAddr,
    output logic                 opndWe,
    output logic [WORD_BITS-1:0] opndWdata,
    input  logic                 opndAck,
    input  logic [WORD_BITS-1:0] opndRdata,
    output logic [WORD_BITS-1:0] acc
);

    logic [2:0] state;
    lvdcWord_u  opnd;
    logic       carry;
    logic       carryIn;
    logic       carryOut;
    logic       resBit;
    logic       serialActive;
    logic       lastBit;

    // Bit 0 is handled in the wordStart cycle itself
    assign serialActive = (state == ALU_SHIFT) || (state == ALU_SYNC && wordStart);
    assign lastBit      = (bitIndex == 5'(WORD_BITS - 1));
    assign opndWdata    = acc;

    ///////////////////////////////
    // One bit of the serial pass
    ///////////////////////////////
    always_comb begin
        carryIn  = wordStart ? 1'b0 : carry;
        resBit   = acc[0];
        carryOut = 1'b0;
        case (execOpcode)
            OP_CLA: resBit = opnd.data[0];
            OP_ADD: begin
                resBit   = acc[0] ^ opnd.data[0] ^ carryIn;
                carryOut = (acc[0] & opnd.data[0]) | (carryIn & (acc[0] ^ opnd.data[0]));
            end
            OP_SUB: begin
                // Here the flop holds a borrow
                resBit   = acc[0] ^ opnd.data[0] ^ carryIn;
                carryOut = (!acc[0] & opnd.data[0]) | (carryIn & !(acc[0] ^ opnd.data[0]));
            end
            OP_AND: resBit = acc[0] & opnd.data[0];
            default: resBit = acc[0];
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= ALU_IDLE;
            acc      <= '0;
            carry    <= 1'b0;
            execAck  <= 1'b0;
            opndReq  <= 1'b0;
            opndAddr <= '0;
            opndWe   <= 1'b0;
        end else begin
            if (serialActive) begin
                acc       <= {resBit, acc[WORD_BITS-1:1]};
                opnd.data <= opnd.data >> 1;
                carry     <= carryOut;
            end

            case (state)
                ALU_IDLE: begin
                    if (execReq && !opndAck) begin
                        opndAddr <= execAddr;
                        if (execOpcode == OP_STO) begin
                            state <= ALU_SYNC;
                        end else begin
                            opndReq <= 1'b1;
                            opndWe  <= 1'b0;
                            state   <= ALU_FETCH;
                        end
                    end
                end
                ALU_FETCH: begin
                    if (opndAck) begin
                        opndReq   <= 1'b0;
                        opnd.data <= opndRdata;
                        state     <= ALU_SYNC;
                    end
                end
                ALU_SYNC: begin
                    if (wordStart) begin
                        state <= ALU_SHIFT;
                    end
                end
                ALU_SHIFT: begin
                    if (lastBit && execOpcode == OP_STO) begin
                        opndReq <= 1'b1;
                        opndWe  <= 1'b1;
                        state   <= ALU_STORE;
                    end else if (lastBit) begin
                        execAck <= 1'b1;
                        state   <= ALU_DONE;
                    end
                end
                ALU_STORE: begin
                    if (opndAck) begin
                        opndReq <= 1'b0;
                        opndWe  <= 1'b0;
                        execAck <= 1'b1;
                        state   <= ALU_DONE;
                    end
                end
                ALU_DONE: begin
                    if (!execReq) begin
                        execAck <= 1'b0;
                        state   <= ALU_IDLE;
                    end
                end
                default: begin
                    state <= ALU_IDLE;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

/* src/lvdcCore.sv */
`timescale 1ns/1ps
`default_nettype none

module lvdcCore
    import lvdcPkg::*;
(
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 extReq,
    input  logic [ADDR_BITS-1:0] extAddr,
    input  logic                 extWe,
    input  logic [WORD_BITS-1:0] extWdata,
    output logic                 extAck,
    output logic [WORD_BITS-1:0] extRdata,
    input  logic                 start,
    output logic                 halted,
    output logic [WORD_BITS-1:0] acc
);

    // Bit timing
    logic [4:0]           bitIndex;
    logic                 wordStart;

    // Memory side of the arbiter
    logic                 memReq;
    logic [ADDR_BITS-1:0] memAddr;
    logic                 memWe;
    logic [WORD_BITS-1:0] memWdata;
    logic                 memAck;
    logic [WORD_BITS-1:0] memRdata;

    // Operand and instruction ports
    logic                 opndReq;
    logic [ADDR_BITS-1:0] opndAddr;
    logic                 opndWe;
    logic [WORD_BITS-1:0] opndWdata;
    logic                 opndAck;
    logic [WORD_BITS-1:0] opndRdata;
    logic                 ifetchReq;
    logic [ADDR_BITS-1:0] ifetchAddr;
    logic                 ifetchAck;
    logic [WORD_BITS-1:0] ifetchRdata;

    // Sequencer to arithmetic handoff
    logic                 execReq;
    logic [OP_BITS-1:0]   execOpcode;
    logic [ADDR_BITS-1:0] execAddr;
    logic                 execAck;

    timingGenerator i_timingGenerator (
        .clk(clk),
        .rst(rst),
        .bitIndex(bitIndex),
        .wordStart(wordStart)
    );

    wordMemory i_wordMemory (
        .clk(clk),
        .rst(rst),
        .memReq(memReq),
        .memAddr(memAddr),
        .memWe(memWe),
        .memWdata(memWdata),
        .memAck(memAck),
        .memRdata(memRdata)
    );

    memoryArbiter i_memoryArbiter (
        .clk(clk),
        .rst(rst),
        .extReq(extReq),
        .extAddr(extAddr),
        .extWe(extWe),
        .extWdata(extWdata),
        .extAck(extAck),
        .extRdata(extRdata),
        .opndReq(opndReq),
        .opndAddr(opndAddr),
        .opndWe(opndWe),
        .opndWdata(opndWdata),
        .opndAck(opndAck),
        .opndRdata(opndRdata),
        .ifetchReq(ifetchReq),
        .ifetchAddr(ifetchAddr),
        .ifetchAck(ifetchAck),
        .ifetchRdata(ifetchRdata),
        .memReq(memReq),
        .memAddr(memAddr),
        .memWe(memWe),
        .memWdata(memWdata),
        .memAck(memAck),
        .memRdata(memRdata)
    );

    instructionSequencer i_instructionSequencer (
        .clk(clk),
        .rst(rst),
        .start(start),
        .halted(halted),
        .ifetchReq(ifetchReq),
        .ifetchAddr(ifetchAddr),
        .ifetchAck(ifetchAck),
        .ifetchRdata(ifetchRdata),
        .execReq(execReq),
        .execOpcode(execOpcode),
        .execAddr(execAddr),
        .execAck(execAck)
    );

    serialArithmetic i_serialArithmetic (
        .clk(clk),
        .rst(rst),
        .bitIndex(bitIndex),
        .wordStart(wordStart),
        .execReq(execReq),
        .execOpcode(execOpcode),
        .execAddr(execAddr),
        .execAck(execAck),
        .opndReq(opndReq),
        .opndAddr(opndAddr),
        .opndWe(opndWe),
        .opndWdata(opndWdata),
        .opndAck(opndAck),
        .opndRdata(opndRdata),
        .acc(acc)
    );

endmodule

`default_nettype wire

/* verification/lvdcClockGen.sv */
`timescale 1ns/1ps

module lvdcClockGen (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // Reset covers the first three rising edges
    initial begin
        rst = 1'b1;
        repeat (3) @(posedge clk);
        rst <= 1'b0;
    end

endmodule

/* verification/lvdcTb.sv */
`timescale 1ns/1ps

module lvdcTb
    import lvdcPkg::*;
();

    localparam int NUM_TESTS  = 14;
    localparam int NUM_FIXED  = 7;
    localparam int ACK_LIMIT  = 100;
    localparam int HALT_LIMIT = 4000;
    localparam logic [ADDR_BITS-1:0] ADDR_A      = 9'h100;
    localparam logic [ADDR_BITS-1:0] ADDR_B      = 9'h101;
    localparam logic [ADDR_BITS-1:0] ADDR_R      = 9'h102;
    localparam logic [ADDR_BITS-1:0] ADDR_POISON = 9'h103;
    localparam logic [WORD_BITS-1:0] POISON      = 26'h155_AA55;

    logic                 clk;
    logic                 rst;
    logic                 extReq;
    logic [ADDR_BITS-1:0] extAddr;
    logic                 extWe;
    logic [WORD_BITS-1:0] extWdata;
    logic                 extAck;
    logic [WORD_BITS-1:0] extRdata;
    logic                 start;
    logic                 halted;
    logic [WORD_BITS-1:0] acc;

    integer               seed;
    logic [WORD_BITS-1:0] tabA   [NUM_TESTS];
    logic [WORD_BITS-1:0] tabB   [NUM_TESTS];
    logic [WORD_BITS-1:0] tabExp [NUM_TESTS];
    logic [OP_BITS-1:0]   tabOp  [NUM_TESTS];
    string                tabName[NUM_TESTS];

    lvdcClockGen i_lvdcClockGen (
        .clk(clk),
        .rst(rst)
    );

    lvdcCore i_lvdcCore (
        .clk(clk),
        .rst(rst),
        .extReq(extReq),
        .extAddr(extAddr),
        .extWe(extWe),
        .extWdata(extWdata),
        .extAck(extAck),
        .extRdata(extRdata),
        .start(start),
        .halted(halted),
        .acc(acc)
    );

    //////////////////////////////
    // Reference model
    //////////////////////////////
    function automatic logic [WORD_BITS-1:0] expectedResult(input logic [OP_BITS-1:0] op,
            input logic [WORD_BITS-1:0] a, input logic [WORD_BITS-1:0] b);
        case (op)
            OP_ADD, OP_TRA: return a + b;
            OP_SUB: return a - b;
            OP_AND: return a & b;
            default: return b;
        endcase
    endfunction

    // Syllable 1 goes in the high half
    function automatic logic [WORD_BITS-1:0] packWord(input logic [OP_BITS-1:0] op0,
            input logic [ADDR_BITS-1:0] addr0, input logic [OP_BITS-1:0] op1,
            input logic [ADDR_BITS-1:0] addr1);
        return {op1, addr1, op0, addr0};
    endfunction

    function automatic logic [WORD_BITS-1:0] fillWord(input logic [ADDR_BITS-1:0] addr);
        return {addr, ~addr, addr[7:0]};
    endfunction

    task automatic setEntry(input int idx, input string name, input logic [WORD_BITS-1:0] a,
            input logic [WORD_BITS-1:0] b, input logic [OP_BITS-1:0] op);
        tabName[idx] = name;
        tabA[idx]    = a;
        tabB[idx]    = b;
        tabOp[idx]   = op;
        tabExp[idx]  = expectedResult(op, a, b);
    endtask

    task automatic buildTable();
        logic [1:0]         pick;
        logic [OP_BITS-1:0] op;
        setEntry(0, "addCarry25", 26'h3FF_FFFF, 26'h000_0001, OP_ADD);
        setEntry(1, "addMsbCarry", 26'h200_0000, 26'h200_0001, OP_ADD);
        setEntry(2, "subBelowZero", 26'h000_0000, 26'h000_0001, OP_SUB);
        setEntry(3, "subBorrowChain", 26'h100_0000, 26'h000_0001, OP_SUB);
        setEntry(4, "andMask", 26'h2AA_AAAA, 26'h3F0_F0F0, OP_AND);
        setEntry(5, "sylOrder", 26'h0AB_CDEF, 26'h000_0101, OP_ADD);
        setEntry(6, "traSkip", 26'h012_3456, 26'h000_7777, OP_TRA);
        for (int i = NUM_FIXED; i < NUM_TESTS; i++) begin
            pick = 2'($random(seed));
            case (pick)
                2'd0: op = OP_ADD;
                2'd1: op = OP_SUB;
                2'd2: op = OP_AND;
                default: op = OP_TRA;
            endcase
            setEntry(i, $sformatf("random%0d", i), 26'($random(seed)), 26'($random(seed)), op);
        end
    endtask

    //////////////////////////////
    // Checking
    //////////////////////////////
    task automatic abortRun(input string what);
        $display("%s", what);
        $display("TEST FAILED");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic checkValue(input string name, input logic [WORD_BITS-1:0] expected,
            input logic [WORD_BITS-1:0] actual);
        assert (actual === expected) else begin
            abortRun($sformatf("MISMATCH %s expected %h actual %h", name, expected, actual));
        end
    endtask

    //////////////////////////////
    // Loader port
    //////////////////////////////
    task automatic waitExtAck(input logic level, input string what);
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (extAck !== level && cycles < ACK_LIMIT) begin
            @(negedge clk);
            cycles++;
        end
        assert (extAck === level) else begin
            abortRun($sformatf("Timed out waiting for extAck to become %0b in %s", level, what));
        end
    endtask

    task automatic memAccess(input logic [ADDR_BITS-1:0] addr, input logic we,
            input logic [WORD_BITS-1:0] wdata, output logic [WORD_BITS-1:0] rdata);
        string what;
        if (we) begin
            what = "a loader write";
        end else begin
            what = "a loader read";
        end
        @(posedge clk);
        extReq   <= 1'b1;
        extAddr  <= addr;
        extWe    <= we;
        extWdata <= wdata;
        waitExtAck(1'b1, what);
        rdata = extRdata;
        @(posedge clk);
        extReq <= 1'b0;
        extWe  <= 1'b0;
        waitExtAck(1'b0, what);
    endtask

    task automatic memWrite(input logic [ADDR_BITS-1:0] addr, input logic [WORD_BITS-1:0] data);
        logic [WORD_BITS-1:0] unused;
        memAccess(addr, 1'b1, data, unused);
    endtask

    task automatic memRead(input logic [ADDR_BITS-1:0] addr, output logic [WORD_BITS-1:0] data);
        memAccess(addr, 1'b0, '0, data);
    endtask

    // The TRA program jumps over word 1, which would load the poison word
    task automatic loadProgram(input int idx);
        if (tabOp[idx] == OP_TRA) begin
            memWrite(9'd0, packWord(OP_CLA, ADDR_A, OP_TRA, 9'd2));
            memWrite(9'd1, packWord(OP_CLA, ADDR_POISON, OP_HLT, 9'd0));
            memWrite(9'd2, packWord(OP_ADD, ADDR_B, OP_STO, ADDR_R));
            memWrite(9'd3, packWord(OP_HLT, 9'd0, OP_HLT, 9'd0));
            memWrite(ADDR_POISON, POISON);
        end else begin
            memWrite(9'd0, packWord(OP_CLA, ADDR_A, tabOp[idx], ADDR_B));
            memWrite(9'd1, packWord(OP_STO, ADDR_R, OP_HLT, 9'd0));
        end
        memWrite(ADDR_A, tabA[idx]);
        memWrite(ADDR_B, tabB[idx]);
        memWrite(ADDR_R, ~tabExp[idx]);
    endtask

    task automatic runProgram(input string name);
        int cycles;
        @(posedge clk);
        start <= 1'b1;
        @(posedge clk);
        start <= 1'b0;
        @(negedge clk);
        checkValue({name, " halted after start"}, '0, {25'd0, halted});
        cycles = 0;
        while (halted !== 1'b1 && cycles < HALT_LIMIT) begin
            @(negedge clk);
            cycles++;
        end
        assert (halted === 1'b1) else begin
            abortRun($sformatf("Timed out waiting for halted in %s", name));
        end
    endtask

    initial begin
        int                   cycles;
        logic [ADDR_BITS-1:0] addr;
        logic [WORD_BITS-1:0] readBack;
        extReq   = 1'b0;
        extAddr  = '0;
        extWe    = 1'b0;
        extWdata = '0;
        start    = 1'b0;
        seed     = 32'ha83e_0c8a;
        buildTable();

        cycles = 0;
        while (rst !== 1'b0 && cycles < 20) begin
            @(negedge clk);
            cycles++;
        end
        assert (rst === 1'b0) else begin
            abortRun("Reset was never released");
        end
        checkValue("halted after reset", '0, {25'd0, halted});
        checkValue("acc after reset", '0, acc);

        // Spread of addresses from 0 up to the last word
        for (int i = 0; i < 8; i++) begin
            addr = 9'(i * 73);
            memWrite(addr, fillWord(addr));
        end
        for (int i = 0; i < 8; i++) begin
            addr = 9'(i * 73);
            memRead(addr, readBack);
            checkValue($sformatf("loader at %h", addr), fillWord(addr), readBack);
        end

        for (int i = 0; i < NUM_TESTS; i++) begin
            loadProgram(i);
            runProgram(tabName[i]);
            checkValue({tabName[i], " acc"}, tabExp[i], acc);
            memRead(ADDR_R, readBack);
            checkValue({tabName[i], " result"}, tabExp[i], readBack);
        end

        $display("TEST OK");
        $finish;
    end

endmodule

/* lvdcCore.f */
src/lvdcPkg.sv
src/timingGenerator.sv
src/wordMemory.sv
src/memoryArbiter.sv
src/instructionSequencer.sv
src/serialArithmetic.sv
src/lvdcCore.sv
verification/lvdcClockGen.sv
verification/lvdcTb.sv
